/* src/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// Address of the first instruction fetch after reset
// Must be even, since the PC steps by whole words
`define LC3B_RESET_PC 16'h0000

`endif

/* src/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

    // ISA opcodes with their LC-3b encodings
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // Second ALU operand
    typedef enum logic [1:0] {
        alumux_sr2     = 2'b00,
        alumux_imm5    = 2'b01,
        alumux_offset6 = 2'b10
    } lc3b_alumux_sel;

    // Register write-back source
    typedef enum logic [1:0] {
        regfilemux_alu   = 2'b00,
        regfilemux_mdr   = 2'b01,
        regfilemux_pcoff = 2'b10
    } lc3b_regfilemux_sel;

    // ADD, AND, NOT layout
    // Tail is sr2 in its low three bits, or imm5 when imm_flag is set
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm_flag;
        logic [4:0] tail;
    } lc3b_operate_fmt;

    // LDR, STR and BR layout
    // dr doubles as the nzp mask for BR and the store source for STR
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] dr;
        logic [2:0] base;
        logic [5:0] offset6;
    } lc3b_offset_fmt;

    typedef union packed {
        lc3b_operate_fmt operate;
        lc3b_offset_fmt  offset;
    } lc3b_instr;

endpackage

`default_nettype wire

/* src/lc3b_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_regfile (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         load,
    input  wire  [2:0]  sr1,
    input  wire  [2:0]  sr2,
    input  wire  [2:0]  dr,
    input  wire  [15:0] in,
    output logic [15:0] reg_a,
    output logic [15:0] reg_b
);

    logic [15:0] regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dr] <= in;
        end
    end

    // Reads see the old value during a write cycle
    assign reg_a = regs[sr1];
    assign reg_b = regs[sr2];

endmodule

`default_nettype wire

/* src/lc3b_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_alu (
    input  wire lc3b_pkg::lc3b_aluop aluop,
    input  wire [15:0]               a,
    input  wire [15:0]               b,
    output logic [15:0]              f
);

    always_comb begin
        case (aluop)
            lc3b_pkg::alu_add: f = a + b;
            lc3b_pkg::alu_and: f = a & b;
            lc3b_pkg::alu_not: f = ~a;
            // Used by STR to move the source into the MDR
            lc3b_pkg::alu_pass: f = b;
            default:           f = b;
        endcase
    end

endmodule

`default_nettype wire

/* src/lc3b_control.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_control (
    input  wire                              clk,
    input  wire                              rst_n,

    input  wire lc3b_pkg::lc3b_opcode        opcode,
    input  wire                              imm_flag,
    input  wire                              branch_enable,

    input  wire                              mem_resp,

    output logic                             load_pc,
    output logic                             load_ir,
    output logic                             load_regfile,
    output logic                             load_mar,
    output logic                             load_mdr,
    output logic                             load_cc,
    output logic                             pcmux_sel,
    output logic                             storemux_sel,
    output logic                             marmux_sel,
    output logic                             mdrmux_sel,
    output lc3b_pkg::lc3b_alumux_sel         alumux_sel,
    output lc3b_pkg::lc3b_regfilemux_sel     regfilemux_sel,
    output lc3b_pkg::lc3b_aluop              aluop,

    output logic                             mem_read,
    output logic                             mem_write
);

    typedef enum logic [3:0] {
        s_fetch1,
        s_fetch2,
        s_fetch3,
        s_decode,
        s_add,
        s_and,
        s_not,
        s_br,
        s_br_taken,
        s_calc_addr,
        s_ldr1,
        s_ldr2,
        s_str1,
        s_str2,
        s_lea
    } state_t;

    state_t state;
    state_t next_state;

    // Datapath controls for the current state
    always_comb begin
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = 1'b0;
        storemux_sel   = 1'b0;
        marmux_sel     = 1'b0;
        mdrmux_sel     = 1'b0;
        alumux_sel     = lc3b_pkg::alumux_sr2;
        regfilemux_sel = lc3b_pkg::regfilemux_alu;
        aluop          = lc3b_pkg::alu_add;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        case (state)
            s_fetch1: begin
                // MAR gets PC, PC steps to the next word
                marmux_sel = 1'b1;
                load_mar   = 1'b1;
                load_pc    = 1'b1;
            end
            s_fetch2: begin
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = 1'b1;
            end
            s_fetch3: begin
                load_ir = 1'b1;
            end
            s_add: begin
                if (imm_flag) begin
                    alumux_sel = lc3b_pkg::alumux_imm5;
                end
                aluop        = lc3b_pkg::alu_add;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            s_and: begin
                if (imm_flag) begin
                    alumux_sel = lc3b_pkg::alumux_imm5;
                end
                aluop        = lc3b_pkg::alu_and;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            s_not: begin
                aluop        = lc3b_pkg::alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            s_br_taken: begin
                pcmux_sel = 1'b1;
                load_pc   = 1'b1;
            end
            s_calc_addr: begin
                // Base register plus offset6 scaled to bytes
                alumux_sel = lc3b_pkg::alumux_offset6;
                aluop      = lc3b_pkg::alu_add;
                load_mar   = 1'b1;
            end
            s_ldr1: begin
                mem_read   = 1'b1;
                mdrmux_sel = 1'b1;
                load_mdr   = 1'b1;
            end
            s_ldr2: begin
                regfilemux_sel = lc3b_pkg::regfilemux_mdr;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            s_str1: begin
                // Store source is read through the second port and passed
                storemux_sel = 1'b1;
                aluop        = lc3b_pkg::alu_pass;
                load_mdr     = 1'b1;
            end
            s_str2: begin
                mem_write = 1'b1;
            end
            s_lea: begin
                regfilemux_sel = lc3b_pkg::regfilemux_pcoff;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;

        case (state)
            s_fetch1: begin
                next_state = s_fetch2;
            end
            s_fetch2: begin
                if (mem_resp) begin
                    next_state = s_fetch3;
                end
            end
            s_fetch3: begin
                next_state = s_decode;
            end
            s_decode: begin
                case (opcode)
                    lc3b_pkg::op_add: next_state = s_add;
                    lc3b_pkg::op_and: next_state = s_and;
                    lc3b_pkg::op_not: next_state = s_not;
                    lc3b_pkg::op_br:  next_state = s_br;
                    lc3b_pkg::op_ldr: next_state = s_calc_addr;
                    lc3b_pkg::op_str: next_state = s_calc_addr;
                    lc3b_pkg::op_lea: next_state = s_lea;
                    // Unsupported opcodes behave as no-ops
                    default:          next_state = s_fetch1;
                endcase
            end
            s_br: begin
                if (branch_enable) begin
                    next_state = s_br_taken;
                end else begin
                    next_state = s_fetch1;
                end
            end
            s_calc_addr: begin
                if (opcode == lc3b_pkg::op_ldr) begin
                    next_state = s_ldr1;
                end else begin
                    next_state = s_str1;
                end
            end
            s_ldr1: begin
                if (mem_resp) begin
                    next_state = s_ldr2;
                end
            end
            s_str1: begin
                next_state = s_str2;
            end
            s_str2: begin
                if (mem_resp) begin
                    next_state = s_fetch1;
                end
            end
            default: begin
                // Single-cycle execute states
                next_state = s_fetch1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

/* src/lc3b_datapath.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc3b_config.svh"

module lc3b_datapath (
    input  wire                              clk,
    input  wire                              rst_n,

    input  wire                              load_pc,
    input  wire                              load_ir,
    input  wire                              load_regfile,
    input  wire                              load_mar,
    input  wire                              load_mdr,
    input  wire                              load_cc,
    input  wire                              pcmux_sel,
    input  wire                              storemux_sel,
    input  wire                              marmux_sel,
    input  wire                              mdrmux_sel,
    input  wire lc3b_pkg::lc3b_alumux_sel    alumux_sel,
    input  wire lc3b_pkg::lc3b_regfilemux_sel regfilemux_sel,
    input  wire lc3b_pkg::lc3b_aluop         aluop,

    input  wire [15:0]                       mem_rdata,

    output lc3b_pkg::lc3b_opcode             opcode,
    output logic                             imm_flag,
    output logic                             branch_enable,
    output logic [15:0]                      mem_address,
    output logic [15:0]                      mem_wdata
);

    lc3b_pkg::lc3b_instr ir;
    logic [15:0] pc;
    logic [15:0] mar;
    logic [15:0] mdr;
    // Condition codes as {n, z, p}
    logic [2:0]  cc;
    logic [2:0]  cc_next;

    logic [2:0]  sr2_addr;
    logic [15:0] reg_a;
    logic [15:0] reg_b;
    logic [15:0] imm5_sext;
    logic [15:0] offset6_sext;
    logic [15:0] offset9_sext;
    logic [15:0] pc_plus2;
    logic [15:0] pc_offset;
    logic [15:0] alu_b;
    logic [15:0] alu_out;
    logic [15:0] regfile_in;

    // STR reads its source register on the second port
    assign sr2_addr = storemux_sel ? ir.offset.dr : ir.operate.tail[2:0];

    assign imm5_sext    = {{11{ir.operate.tail[4]}}, ir.operate.tail};
    assign offset6_sext = {{9{ir.offset.offset6[5]}}, ir.offset.offset6, 1'b0};
    // PCoffset9 spans the low nine bits of the word
    assign offset9_sext = {{6{ir[8]}}, ir[8:0], 1'b0};

    assign pc_plus2  = pc + 16'd2;
    assign pc_offset = pc + offset9_sext;

    lc3b_regfile i_lc3b_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load_regfile),
        .sr1   (ir.operate.sr1),
        .sr2   (sr2_addr),
        .dr    (ir.operate.dr),
        .in    (regfile_in),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_comb begin
        case (alumux_sel)
            lc3b_pkg::alumux_imm5:    alu_b = imm5_sext;
            lc3b_pkg::alumux_offset6: alu_b = offset6_sext;
            default:                  alu_b = reg_b;
        endcase
    end

    lc3b_alu i_lc3b_alu (
        .aluop (aluop),
        .a     (reg_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    always_comb begin
        case (regfilemux_sel)
            lc3b_pkg::regfilemux_mdr:   regfile_in = mdr;
            lc3b_pkg::regfilemux_pcoff: regfile_in = pc_offset;
            default:                    regfile_in = alu_out;
        endcase
    end

    // Flags follow the value being written back
    always_comb begin
        if (regfile_in[15]) begin
            cc_next = 3'b100;
        end else if (regfile_in == 16'h0000) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc  <= `LC3B_RESET_PC;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            cc  <= '0;
        end else begin
            if (load_pc) begin
                pc <= pcmux_sel ? pc_offset : pc_plus2;
            end
            if (load_ir) begin
                ir <= lc3b_pkg::lc3b_instr'(mdr);
            end
            if (load_mar) begin
                mar <= marmux_sel ? pc : alu_out;
            end
            if (load_mdr) begin
                mdr <= mdrmux_sel ? mem_rdata : alu_out;
            end
            if (load_cc) begin
                cc <= cc_next;
            end
        end
    end

    assign opcode        = ir.operate.opcode;
    assign imm_flag      = ir.operate.imm_flag;
    // Taken when the nzp mask overlaps the stored flags
    assign branch_enable = |(ir.offset.dr & cc);

    assign mem_address = mar;
    assign mem_wdata   = mdr;

endmodule

`default_nettype wire

/* src/lc3b_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module lc3b_cpu (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [15:0] mem_rdata,
    input  wire         mem_resp,
    output logic [15:0] mem_address,
    output logic [15:0] mem_wdata,
    output logic        mem_read,
    output logic        mem_write
);

    logic load_pc;
    logic load_ir;
    logic load_regfile;
    logic load_mar;
    logic load_mdr;
    logic load_cc;
    logic pcmux_sel;
    logic storemux_sel;
    logic marmux_sel;
    logic mdrmux_sel;
    lc3b_pkg::lc3b_alumux_sel     alumux_sel;
    lc3b_pkg::lc3b_regfilemux_sel regfilemux_sel;
    lc3b_pkg::lc3b_aluop          aluop;

    // Decode feedback
    lc3b_pkg::lc3b_opcode opcode;
    logic imm_flag;
    logic branch_enable;

    lc3b_control i_lc3b_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .opcode         (opcode),
        .imm_flag       (imm_flag),
        .branch_enable  (branch_enable),
        .mem_resp       (mem_resp),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .aluop          (aluop),
        .mem_read       (mem_read),
        .mem_write      (mem_write)
    );

    lc3b_datapath i_lc3b_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_pc        (load_pc),
        .load_ir        (load_ir),
        .load_regfile   (load_regfile),
        .load_mar       (load_mar),
        .load_mdr       (load_mdr),
        .load_cc        (load_cc),
        .pcmux_sel      (pcmux_sel),
        .storemux_sel   (storemux_sel),
        .marmux_sel     (marmux_sel),
        .mdrmux_sel     (mdrmux_sel),
        .alumux_sel     (alumux_sel),
        .regfilemux_sel (regfilemux_sel),
        .aluop          (aluop),
        .mem_rdata      (mem_rdata),
        .opcode         (opcode),
        .imm_flag       (imm_flag),
        .branch_enable  (branch_enable),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata)
    );

endmodule

`default_nettype wire

/* bench/lc3b_cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "lc3b_config.svh"

module lc3b_cpu_tb;

    logic        clk;
    logic        rst_n;
    logic [15:0] mem_rdata;
    logic        mem_resp;
    logic [15:0] mem_address;
    logic [15:0] mem_wdata;
    logic        mem_read;
    logic        mem_write;

    // Memory seen by the DUT and the shadow copy used by the model
    logic [15:0] mem [32768];
    logic [15:0] m_mem [32768];
    logic [15:0] prog [512];
    int          prog_len;

    // Instruction-level model state
    logic [15:0] m_pc;
    logic [15:0] m_regs [8];
    logic [2:0]  m_cc;

    integer      seed;
    logic [31:0] draw;
    logic [1:0]  wait_len;
    logic [1:0]  wait_left;
    logic        busy;

    // Reset level seen at the previous rising edge
    logic        rst_q;

    logic        running;
    logic        done;
    logic        timed_out;
    logic [15:0] marker_addr;
    logic [15:0] e_addr;
    logic [15:0] e_data;
    logic        found;
    int          steps;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    lc3b_cpu i_lc3b_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    always #10 clk = ~clk;

    // Memory with 0 to 3 wait cycles per request
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_resp <= 1'b0;
            busy     <= 1'b0;
        end else if (mem_resp) begin
            mem_resp <= 1'b0;
            if (mem_write) begin
                mem[mem_address[15:1]] <= mem_wdata;
            end
        end else if (mem_read || mem_write) begin
            if (!busy) begin
                draw     = $random(seed);
                wait_len = draw[1:0];
                if (wait_len == 2'd0) begin
                    mem_resp  <= 1'b1;
                    mem_rdata <= mem[mem_address[15:1]];
                end else begin
                    busy      <= 1'b1;
                    wait_left <= wait_len - 2'd1;
                end
            end else if (wait_left == 2'd0) begin
                busy      <= 1'b0;
                mem_resp  <= 1'b1;
                mem_rdata <= mem[mem_address[15:1]];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // Executes one instruction on the model, returns 1 for a store
    function automatic logic lc3b_step(output logic [15:0] st_addr,
                                       output logic [15:0] st_data);
        logic [15:0] instr;
        logic [3:0]  op;
        logic [2:0]  dr;
        logic [2:0]  sr1;
        logic [15:0] b;
        logic [15:0] addr;
        logic [15:0] result;
        logic        wr;
        logic        stored;
        instr   = m_mem[m_pc[15:1]];
        m_pc    = m_pc + 16'd2;
        op      = instr[15:12];
        dr      = instr[11:9];
        sr1     = instr[8:6];
        b       = instr[5] ? {{11{instr[4]}}, instr[4:0]} : m_regs[instr[2:0]];
        addr    = m_regs[sr1] + {{9{instr[5]}}, instr[5:0], 1'b0};
        result  = '0;
        wr      = 1'b0;
        stored  = 1'b0;
        st_addr = '0;
        st_data = '0;
        case (op)
            4'b0001: begin
                result = m_regs[sr1] + b;
                wr     = 1'b1;
            end
            4'b0101: begin
                result = m_regs[sr1] & b;
                wr     = 1'b1;
            end
            4'b1001: begin
                result = ~m_regs[sr1];
                wr     = 1'b1;
            end
            4'b1110: begin
                result = m_pc + {{6{instr[8]}}, instr[8:0], 1'b0};
                wr     = 1'b1;
            end
            4'b0110: begin
                result = m_mem[addr[15:1]];
                wr     = 1'b1;
            end
            4'b0111: begin
                m_mem[addr[15:1]] = m_regs[dr];
                st_addr = addr;
                st_data = m_regs[dr];
                stored  = 1'b1;
            end
            4'b0000: begin
                if ((dr & m_cc) != 3'b000) begin
                    m_pc = m_pc + {{6{instr[8]}}, instr[8:0], 1'b0};
                end
            end
            default: begin
            end
        endcase
        if (wr) begin
            m_regs[dr] = result;
            if (result[15]) begin
                m_cc = 3'b100;
            end else if (result == 16'h0000) begin
                m_cc = 3'b010;
            end else begin
                m_cc = 3'b001;
            end
        end
        return stored;
    endfunction

    // Compare each accepted write with the next store of the model
    always @(posedge clk) begin
        if (rst_n && running && mem_write && mem_resp) begin
            found = 1'b0;
            steps = 0;
            while (!found && steps < 400) begin
                found = lc3b_step(e_addr, e_data);
                steps++;
            end
            checks++;
            if (!found) begin
                $display("Write to %h at %0t ns where the model makes no store",
                         mem_address, $time);
                errors++;
            end else begin
                if (mem_address !== e_addr) begin
                    $display("Error: %0t ns, mem_address expected %h actual %h",
                             $time, e_addr, mem_address);
                    errors++;
                end
                if (mem_wdata !== e_data) begin
                    $display("Error: %0t ns, mem_wdata expected %h actual %h",
                             $time, e_data, mem_wdata);
                    errors++;
                end
            end
            if (mem_address[0] !== 1'b0) begin
                $display("Write to odd address %h at %0t ns", mem_address, $time);
                errors++;
            end
            if (mem_address == marker_addr) begin
                done = 1'b1;
            end
        end
    end

    // No memory request once the synchronous reset has taken hold
    always @(posedge clk) begin
        if (!rst_n && !rst_q && (mem_read !== 1'b0 || mem_write !== 1'b0)) begin
            $display("Memory request during reset at %0t ns", $time);
            errors++;
        end
        rst_q = rst_n;
    end

    function automatic logic [15:0] op_reg(logic [3:0] op, int dr, int sr1, int sr2);
        return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic logic [15:0] op_imm(logic [3:0] op, int dr, int sr1, int imm);
        return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] enc_not(int dr, int sr);
        return {4'b1001, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    function automatic logic [15:0] enc_br(int nzp, int off);
        return {4'b0000, nzp[2:0], off[8:0]};
    endfunction

    function automatic logic [15:0] enc_mem(logic [3:0] op, int r, int base, int off);
        return {op, r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic logic [15:0] enc_lea(int dr, int off);
        return {4'b1110, dr[2:0], off[8:0]};
    endfunction

    task automatic emit(input logic [15:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // R7 points at the data area, 0x200 past the first instruction
    task automatic start_program();
        prog_len = 0;
        emit(enc_lea(7, 255));
    endtask

    // Final store to the marker word, then spin in place
    task automatic finish_program(input int r);
        emit(enc_mem(lc3b_pkg::op_str, r, 7, 31));
        emit(enc_br(7, -1));
    endtask

    task automatic run_program(input string name);
        logic [15:0] rp;
        int          errs_before;
        int          checks_before;
        int          limit;
        int          cycles;
        rp            = `LC3B_RESET_PC;
        errs_before   = errors;
        checks_before = checks;
        @(posedge clk);
        rst_n   <= 1'b0;
        running = 1'b0;
        done    = 1'b0;
        for (int i = 0; i < 32768; i++) begin
            mem[i]   = {i[14:0], 1'b0} ^ 16'hc35a;
            m_mem[i] = {i[14:0], 1'b0} ^ 16'hc35a;
        end
        for (int j = 0; j < prog_len; j++) begin
            mem[rp[15:1] + j[14:0]]   = prog[j];
            m_mem[rp[15:1] + j[14:0]] = prog[j];
        end
        m_pc = rp;
        m_cc = 3'b000;
        for (int k = 0; k < 8; k++) begin
            m_regs[k] = '0;
        end
        marker_addr = rp + 16'h023e;
        repeat (8) @(posedge clk);
        rst_n   <= 1'b1;
        running = 1'b1;
        limit   = prog_len * 16 + 8;
        cycles  = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        running = 1'b0;
        tests_run++;
        if (!done) begin
            $display("Test %s timed out after %0d cycles before its final store",
                     name, cycles);
            timed_out = 1'b1;
            errors++;
        end
        if (errors != errs_before) begin
            tests_failed++;
            $display("Test %s: %0d stores checked, %0d errors, failed",
                     name, checks - checks_before, errors - errs_before);
        end else begin
            $display("Test %s: %0d stores checked, ok", name, checks - checks_before);
        end
    endtask

    task automatic build_random_program();
        logic [31:0] r;
        logic [2:0]  d;
        int          kind;
        int          max_off;
        int          off;
        start_program();
        for (int i = 0; i < 40; i++) begin
            r       = $random(seed);
            kind    = int'(r[31:29]) % 7;
            d       = (r[5:3] == 3'd7) ? 3'd6 : r[5:3];
            max_off = 39 - i;
            case (kind)
                0: emit(r[17] ? op_imm(lc3b_pkg::op_add, d, r[8:6], r[16:12])
                              : op_reg(lc3b_pkg::op_add, d, r[8:6], r[11:9]));
                1: emit(r[17] ? op_imm(lc3b_pkg::op_and, d, r[8:6], r[16:12])
                              : op_reg(lc3b_pkg::op_and, d, r[8:6], r[11:9]));
                2: emit(enc_not(d, r[8:6]));
                3: begin
                    off = (int'(r[22:21]) < max_off) ? int'(r[22:21]) : max_off;
                    emit(enc_br(r[20:18], off));
                end
                4: emit(enc_mem(lc3b_pkg::op_ldr, d, 7, r[28:23]));
                5: emit(enc_mem(lc3b_pkg::op_str, r[5:3], 7, int'(r[28:23]) % 56 - 32));
                default: emit(enc_lea(d, r[28:20]));
            endcase
        end
        for (int k = 0; k < 7; k++) begin
            emit(enc_mem(lc3b_pkg::op_str, k, 7, 24 + k));
        end
        finish_program(7);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        mem_rdata    = '0;
        mem_resp     = 1'b0;
        busy         = 1'b0;
        wait_left    = '0;
        rst_q        = 1'b1;
        seed         = 32'hf7c3_a621;
        running      = 1'b0;
        done         = 1'b0;
        timed_out    = 1'b0;
        marker_addr  = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_program();
        emit(op_imm(lc3b_pkg::op_and, 0, 0, 0));
        emit(op_imm(lc3b_pkg::op_add, 0, 0, 13));
        emit(op_imm(lc3b_pkg::op_and, 1, 1, 0));
        emit(op_imm(lc3b_pkg::op_add, 1, 1, -9));
        emit(op_reg(lc3b_pkg::op_add, 2, 0, 1));
        emit(enc_mem(lc3b_pkg::op_str, 2, 7, 0));
        emit(op_reg(lc3b_pkg::op_and, 3, 0, 1));
        emit(enc_mem(lc3b_pkg::op_str, 3, 7, 1));
        emit(op_imm(lc3b_pkg::op_add, 4, 1, -16));
        emit(enc_mem(lc3b_pkg::op_str, 4, 7, 2));
        emit(op_imm(lc3b_pkg::op_and, 5, 0, -4));
        emit(enc_mem(lc3b_pkg::op_str, 5, 7, 3));
        emit(op_reg(lc3b_pkg::op_add, 6, 2, 4));
        finish_program(6);
        run_program("add_and");

        // Marker value 1 means taken, 3 means not taken
        start_program();
        emit(op_imm(lc3b_pkg::op_and, 0, 0, 0));
        emit(op_imm(lc3b_pkg::op_add, 0, 0, 5));
        for (int g = 0; g < 24; g++) begin
            emit(op_imm(lc3b_pkg::op_and, 2, 2, 0));
            emit(op_imm(lc3b_pkg::op_add, 2, 2, 1));
            case (g / 8)
                0: emit(enc_not(3, 0));
                1: emit(op_imm(lc3b_pkg::op_and, 3, 3, 0));
                default: emit(op_imm(lc3b_pkg::op_add, 3, 0, 0));
            endcase
            emit(enc_br(g % 8, 1));
            emit(op_imm(lc3b_pkg::op_add, 2, 2, 2));
            emit(enc_mem(lc3b_pkg::op_str, 2, 7, g));
        end
        finish_program(3);
        if (!timed_out) run_program("not_branch");

        start_program();
        emit(op_imm(lc3b_pkg::op_and, 0, 0, 0));
        emit(op_imm(lc3b_pkg::op_add, 0, 0, 11));
        emit(enc_mem(lc3b_pkg::op_str, 0, 7, -5));
        emit(enc_mem(lc3b_pkg::op_ldr, 1, 7, -5));
        emit(op_imm(lc3b_pkg::op_add, 1, 1, 1));
        emit(enc_mem(lc3b_pkg::op_str, 1, 7, 6));
        emit(op_imm(lc3b_pkg::op_add, 5, 7, 8));
        emit(enc_mem(lc3b_pkg::op_ldr, 2, 5, -9));
        emit(enc_mem(lc3b_pkg::op_str, 2, 5, 3));
        emit(enc_mem(lc3b_pkg::op_ldr, 3, 7, 20));
        emit(enc_mem(lc3b_pkg::op_str, 3, 5, -1));
        finish_program(3);
        if (!timed_out) run_program("load_store");

        start_program();
        emit(enc_lea(0, 5));
        emit(enc_mem(lc3b_pkg::op_str, 0, 7, 0));
        emit(enc_lea(1, -3));
        emit(enc_mem(lc3b_pkg::op_str, 1, 7, 1));
        emit(enc_lea(2, 0));
        emit(enc_mem(lc3b_pkg::op_str, 2, 7, 2));
        emit(enc_lea(3, -100));
        finish_program(3);
        if (!timed_out) run_program("lea");

        for (int p = 0; p < 3; p++) begin
            build_random_program();
            if (!timed_out) run_program("random");
        end

        // Long run of non-store work before the first write
        start_program();
        emit(op_imm(lc3b_pkg::op_and, 0, 0, 0));
        emit(op_imm(lc3b_pkg::op_add, 0, 0, 7));
        emit(enc_lea(1, 3));
        emit(enc_br(1, 1));
        emit(op_imm(lc3b_pkg::op_add, 0, 0, 1));
        emit(enc_mem(lc3b_pkg::op_ldr, 2, 7, 4));
        emit(enc_not(3, 2));
        emit(enc_mem(lc3b_pkg::op_str, 0, 7, 2));
        emit(enc_mem(lc3b_pkg::op_str, 3, 7, -2));
        finish_program(3);
        if (!timed_out) run_program("first_write");

        $display("Tests: %0d run, %0d failed, %0d stores checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/lc3b_pkg.sv
src/lc3b_regfile.sv
src/lc3b_alu.sv
src/lc3b_control.sv
src/lc3b_datapath.sv
src/lc3b_cpu.sv
bench/lc3b_cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LC-3b testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module lc3b_cpu_tb -o lc3b_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/lc3b_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
